// ==== tb.f ====
source/io_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/perf_counters.sv
source/io_control.sv
source/io_subsystem.sv
bench/tb_io.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  - source/io_pkg.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/perf_counters.sv
  - source/io_control.sv
  - source/io_subsystem.sv
  - target: test
    files:
      - bench/tb_io.sv

// ==== bench/tb_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_io import io_pkg::*; ();

	localparam int POLL_LIMIT = 400;
	localparam int STATUS_TX_BIT = 0;
	localparam int STATUS_RX_BIT = 1;

	logic       clk = 1'b0;
	logic       cpu_rst = 1'b1;
	io_adr_t    adr = '0;
	logic       io_load = 1'b0;
	logic       iowea = 1'b0;
	logic [3:0] wea = 4'd0;
	xlen_t      din_io = '0;
	logic       instr_stop = 1'b0;
	logic       uart_serial_in = 1'b1;
	xlen_t      dout_io;
	logic       uart_serial_out;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	// Reference counters and edge tallies kept by the bench
	xlen_t m_cycle = '0;
	xlen_t m_instr = '0;
	xlen_t m_edges = '0;
	xlen_t m_run_edges = '0;

	// Bytes decoded from the serial output
	byte_t tx_seen[$];

	io_subsystem dut_i (
		.clk             (clk),
		.cpu_rst         (cpu_rst),
		.adr             (adr),
		.io_load         (io_load),
		.iowea           (iowea),
		.wea             (wea),
		.din_io          (din_io),
		.instr_stop      (instr_stop),
		.uart_serial_in  (uart_serial_in),
		.dout_io         (dout_io),
		.uart_serial_out (uart_serial_out)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (cpu_rst) begin
			m_cycle <= '0;
			m_instr <= '0;
		end else if (iowea && adr == ADR_CNT_CLEAR && wea != 4'd0) begin
			m_cycle <= '0;
			m_instr <= '0;
		end else begin
			m_cycle <= m_cycle + 1;
			if (!instr_stop) begin
				m_instr <= m_instr + 1;
			end
		end
		m_edges <= m_edges + 1;
		if (!instr_stop) begin
			m_run_edges <= m_run_edges + 1;
		end
	end

	// 8N1 receiver on the transmit line, sampling each bit near its middle
	initial begin : line_monitor
		byte_t b;
		logic  start_ok;
		forever begin
			@(negedge clk);
			if (!cpu_rst && !uart_serial_out) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				start_ok = !uart_serial_out;
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					b[i] = uart_serial_out;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				assert (start_ok && uart_serial_out) else begin
					errors++;
					$display("Framing error on the serial output at %0t", $time);
				end
				tx_seen.push_back(b);
			end
		end
	end

	task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// All bus tasks start and end just after a falling edge
	task automatic bus_read(input io_adr_t a, output xlen_t data);
		adr = a;
		io_load = 1'b1;
		@(posedge clk);
		@(negedge clk);
		io_load = 1'b0;
		data = dout_io;
	endtask

	task automatic bus_write(input io_adr_t a, input logic [3:0] lanes, input xlen_t data);
		adr = a;
		iowea = 1'b1;
		wea = lanes;
		din_io = data;
		@(posedge clk);
		@(negedge clk);
		iowea = 1'b0;
		wea = 4'd0;
	endtask

	task automatic read_counter(input io_adr_t a, output xlen_t got, output xlen_t edges,
		output xlen_t run_edges);
		xlen_t exp;
		exp = (a == ADR_CYCLE_CNT) ? m_cycle : m_instr;
		edges = m_edges;
		run_edges = m_run_edges;
		bus_read(a, got);
		check_word((a == ADR_CYCLE_CNT) ? "cycle counter" : "instruction counter", got, exp);
	endtask

	task automatic idle_cycles(input int n, input logic shake_stop);
		for (int i = 0; i < n; i++) begin
			if (shake_stop) begin
				instr_stop = 1'($urandom_range(0, 1));
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_status_bit(input int pos, input logic level, input string what);
		xlen_t w;
		int    n;
		n = 0;
		bus_read(ADR_UART_CTRL, w);
		while (w[pos] !== level && n < POLL_LIMIT) begin
			bus_read(ADR_UART_CTRL, w);
			n++;
		end
		if (w[pos] !== level) begin
			timeouts++;
			$display("Timeout at %0t: status never showed %s", $time, what);
		end
	endtask

	task automatic expect_line_byte(input byte_t exp);
		byte_t got;
		int    n;
		n = 0;
		while (tx_seen.size() == 0 && n < POLL_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (tx_seen.size() == 0) begin
			timeouts++;
			$display("Timeout at %0t: no frame appeared on the serial output", $time);
		end else begin
			got = tx_seen.pop_front();
			check_word("serial output byte", xlen_t'(got), xlen_t'(exp));
		end
	endtask

	task automatic send_frame(input byte_t b);
		uart_serial_in = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			uart_serial_in = b[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		uart_serial_in = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	initial begin
		xlen_t   w;
		xlen_t   v1;
		xlen_t   v2;
		xlen_t   e1;
		xlen_t   e2;
		xlen_t   r1;
		xlen_t   r2;
		byte_t   b;
		io_adr_t a;
		void'($urandom(32'h1391c133));
		repeat (16) @(negedge clk);
		cpu_rst = 1'b0;

		check_word("read data after reset", dout_io, '0);
		bus_read(ADR_UART_CTRL, w);
		check_word("status after reset", w, 32'h1);
		for (int i = 0; i < 20; i++) begin
			check_word("idle serial output", xlen_t'(uart_serial_out), 32'h1);
			@(negedge clk);
		end

		for (int i = 0; i < 20; i++) begin
			wait_status_bit(STATUS_TX_BIT, 1'b1, "transmitter ready");
			w = $urandom;
			bus_write(ADR_UART_TX, 4'b0001, w);
			bus_read(ADR_UART_CTRL, v1);
			check_word("tx_ready during frame", xlen_t'(v1[STATUS_TX_BIT]), '0);
			expect_line_byte(w[7:0]);
		end

		for (int i = 0; i < 20; i++) begin
			b = byte_t'($urandom);
			fork
				send_frame(b);
				wait_status_bit(STATUS_RX_BIT, 1'b1, "received byte waiting");
			join
			bus_read(ADR_UART_RX, w);
			check_word("received byte", w, {24'd0, b});
			bus_read(ADR_UART_CTRL, w);
			check_word("rx_valid after read", xlen_t'(w[STATUS_RX_BIT]), '0);
		end

		// Counter deltas against edges seen between the two address cycles
		for (int i = 0; i < 8; i++) begin
			a = i[0] ? ADR_INSTR_CNT : ADR_CYCLE_CNT;
			idle_cycles(1, 1'b1);
			read_counter(a, v1, e1, r1);
			idle_cycles($urandom_range(1, 60), 1'b1);
			read_counter(a, v2, e2, r2);
			check_word("counter delta", v2 - v1, (a == ADR_CYCLE_CNT) ? e2 - e1 : r2 - r1);
		end

		for (int i = 0; i < 4; i++) begin
			idle_cycles($urandom_range(5, 40), 1'b1);
			bus_write(ADR_CNT_CLEAR, 4'($urandom_range(1, 15)), $urandom);
			read_counter(ADR_CYCLE_CNT, v1, e1, r1);
			check_word("cycle counter after clear", v1, '0);
			read_counter(ADR_INSTR_CNT, v1, e1, r1);
			idle_cycles($urandom_range(5, 40), 1'b1);
			bus_write(ADR_CNT_CLEAR, 4'd0, $urandom);
			read_counter(ADR_CYCLE_CNT, v1, e1, r1);
			read_counter(ADR_INSTR_CNT, v1, e1, r1);
		end
		instr_stop = 1'b0;

		for (int i = 0; i < 20; i++) begin
			a = io_adr_t'($urandom_range(0, 25));
			a = (a == 5'd0) ? 5'd3 : a + 5'd6;
			bus_read(a, w);
			check_word("unmapped address", w, '0);
		end

		// The second store lands while the transmitter is busy
		wait_status_bit(STATUS_TX_BIT, 1'b1, "transmitter ready");
		b = byte_t'($urandom);
		bus_write(ADR_UART_TX, 4'b0001, {24'd0, b});
		idle_cycles(3, 1'b0);
		bus_write(ADR_UART_TX, 4'b0001, {24'd0, ~b});
		wait_status_bit(STATUS_TX_BIT, 1'b1, "transmitter ready");
		expect_line_byte(b);
		idle_cycles(12 * CLKS_PER_BIT, 1'b0);
		check_word("frames after ignored store", xlen_t'(tx_seen.size()), '0);
		check_word("serial output after ignored store", xlen_t'(uart_serial_out), 32'h1);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/io_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_subsystem import io_pkg::*; (
	input  logic       clk,
	input  logic       cpu_rst,
	input  io_adr_t    adr,
	input  logic       io_load,
	input  logic       iowea,
	input  logic [3:0] wea,
	input  xlen_t      din_io,
	input  logic       instr_stop,
	input  logic       uart_serial_in,
	output xlen_t      dout_io,
	output logic       uart_serial_out
);

	// Each UART half drives its own member of the status struct
	wire uart_status_t status;

	byte_t tx_data;
	logic  tx_valid;
	byte_t rx_data;
	logic  rx_ready;
	logic  clear;
	xlen_t cycle_cnt;
	xlen_t instr_cnt;

	io_control u_io_control (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.adr       (adr),
		.io_load   (io_load),
		.iowea     (iowea),
		.wea       (wea),
		.din_io    (din_io),
		.status    (status),
		.rx_data   (rx_data),
		.cycle_cnt (cycle_cnt),
		.instr_cnt (instr_cnt),
		.dout_io   (dout_io),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.rx_ready  (rx_ready),
		.clear     (clear)
	);

	uart_tx u_uart_tx (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.tx_data    (tx_data),
		.tx_valid   (tx_valid),
		.tx_ready   (status.tx_ready),
		.serial_out (uart_serial_out)
	);

	uart_rx u_uart_rx (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.serial_in (uart_serial_in),
		.rx_ready  (rx_ready),
		.rx_data   (rx_data),
		.rx_valid  (status.rx_valid)
	);

	perf_counters u_perf_counters (
		.clk        (clk),
		.cpu_rst    (cpu_rst),
		.clear      (clear),
		.instr_stop (instr_stop),
		.cycle_cnt  (cycle_cnt),
		.instr_cnt  (instr_cnt)
	);

endmodule

`default_nettype wire

// ==== source/io_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_control import io_pkg::*; (
	input  logic         clk,
	input  logic         cpu_rst,
	input  io_adr_t      adr,
	input  logic         io_load,
	input  logic         iowea,
	input  logic [3:0]   wea,
	input  xlen_t        din_io,
	input  uart_status_t status,
	input  byte_t        rx_data,
	input  xlen_t        cycle_cnt,
	input  xlen_t        instr_cnt,
	output xlen_t        dout_io,
	output byte_t        tx_data,
	output logic         tx_valid,
	output logic         rx_ready,
	output logic         clear
);

	logic  sel_rx;
	logic  sel_tx;
	logic  sel_clear;
	xlen_t status_word;
	xlen_t rx_word;
	xlen_t rd_word;

	assign sel_rx = (adr == ADR_UART_RX);
	assign sel_tx = (adr == ADR_UART_TX);
	assign sel_clear = (adr == ADR_CNT_CLEAR);

	// Store to the transmit register hands the low byte to the UART
	assign tx_valid = iowea && sel_tx;
	assign tx_data = tx_valid ? din_io[7:0] : '0;

	// Loading the receive register acknowledges the held byte
	assign rx_ready = io_load && sel_rx;

	// A clear store needs at least one byte lane enabled
	assign clear = iowea && sel_clear && (wea != 4'd0);

	assign status_word = xlen_t'(status);
	assign rx_word = xlen_t'(rx_data);

	// The transmit register is write only and reads back as zero
	always_comb begin
		case (adr)
			ADR_UART_CTRL: rd_word = status_word;
			ADR_UART_RX: rd_word = rx_word;
			ADR_CYCLE_CNT: rd_word = cycle_cnt;
			ADR_INSTR_CNT: rd_word = instr_cnt;
			default: rd_word = '0;
		endcase
	end

	// Read data follows the address by one cycle whether or not io_load is set
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			dout_io <= '0;
		end else begin
			dout_io <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== source/perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_counters import io_pkg::*; (
	input  logic  clk,
	input  logic  cpu_rst,
	input  logic  clear,
	input  logic  instr_stop,
	output xlen_t cycle_cnt,
	output xlen_t instr_cnt
);

	// Free-running cycle counter, wraps at 2**32
	always_ff @(posedge clk) begin
		if (cpu_rst || clear) begin
			cycle_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	// Retired instructions, counted only while the pipeline is not stalled
	always_ff @(posedge clk) begin
		if (cpu_rst || clear) begin
			instr_cnt <= '0;
		end else if (!instr_stop) begin
			instr_cnt <= instr_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx import io_pkg::*; (
	input  logic  clk,
	input  logic  cpu_rst,
	input  logic  serial_in,
	input  logic  rx_ready,
	output byte_t rx_data,
	output logic  rx_valid
);

	rx_state_t  state;
	tick_t      tick;
	bit_idx_t   bit_idx;
	byte_t      shift;
	logic [1:0] sync_ff;
	logic       line_prev;
	logic       line;
	logic       fall;
	logic       sample_data;
	logic       stop_mid;

	// Two flop synchronizer, then one more flop for edge detection
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			sync_ff <= 2'b11;
			line_prev <= 1'b1;
		end else begin
			sync_ff <= {sync_ff[0], serial_in};
			line_prev <= sync_ff[1];
		end
	end

	assign line = sync_ff[1];
	assign fall = line_prev && !line;

	assign sample_data = (state == RX_DATA) && (tick == TICK_LAST);
	assign stop_mid = (state == RX_STOP) && (tick == TICK_LAST);

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			state <= RX_IDLE;
			tick <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					// The cycle of the falling edge is the first cycle of the start bit
					tick <= tick_t'(1);
					if (fall) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (tick == TICK_HALF) begin
						tick <= '0;
						bit_idx <= '0;
						// A start bit that is high again by mid-bit was a glitch
						state <= line ? RX_IDLE : RX_DATA;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				RX_DATA: begin
					if (tick == TICK_LAST) begin
						tick <= '0;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						tick <= tick + 1'b1;
					end
				end
				RX_STOP: begin
					// Back to idle at mid stop bit so the next start edge is not missed
					if (tick == TICK_LAST) begin
						state <= RX_IDLE;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// Bits arrive LSB first and shift in from the top
	always_ff @(posedge clk) begin
		if (sample_data) begin
			shift <= {line, shift[7:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (stop_mid) begin
			rx_data <= shift;
		end
	end

	// A completed frame wins over an acknowledge in the same cycle
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			rx_valid <= 1'b0;
		end else if (stop_mid) begin
			rx_valid <= 1'b1;
		end else if (rx_ready) begin
			rx_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx import io_pkg::*; (
	input  logic  clk,
	input  logic  cpu_rst,
	input  byte_t tx_data,
	input  logic  tx_valid,
	output logic  tx_ready,
	output logic  serial_out
);

	tx_state_t state;
	tick_t     tick;
	bit_idx_t  bit_idx;
	byte_t     shift;
	logic      bit_done;

	assign bit_done = (tick == TICK_LAST);
	assign tx_ready = (state == TX_IDLE);

	// The tick counter sits at zero while idle and restarts at every bit boundary
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			tick <= '0;
		end else if (state == TX_IDLE || bit_done) begin
			tick <= '0;
		end else begin
			tick <= tick + 1'b1;
		end
	end

	// The next data bit always waits in shift[0]
	always_ff @(posedge clk) begin
		if (tx_valid && tx_ready) begin
			shift <= tx_data;
		end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
			shift <= shift >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			state <= TX_IDLE;
			serial_out <= 1'b1;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_valid) begin
						// Start bit goes out in the cycle after acceptance
						state <= TX_START;
						serial_out <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_done) begin
						state <= TX_DATA;
						serial_out <= shift[0];
						bit_idx <= '0;
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state <= TX_STOP;
							serial_out <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							serial_out <= shift[0];
						end
					end
				end
				TX_STOP: begin
					if (bit_done) begin
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
					serial_out <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/io_pkg.sv ====
`default_nettype none

package io_pkg;

	localparam int unsigned CPU_CLOCK_FREQ = 50_000_000;
	localparam int unsigned BAUD_RATE = 3_125_000;

	// Clock cycles per serial bit, 16 with the default clock and baud rate
	localparam int unsigned CLKS_PER_BIT = CPU_CLOCK_FREQ / BAUD_RATE;
	localparam int unsigned TICK_W = $clog2(CLKS_PER_BIT);

	typedef logic [31:0] xlen_t;
	typedef logic [4:0] io_adr_t;
	typedef logic [7:0] byte_t;

	// Counts the clock cycles within one serial bit
	typedef logic [TICK_W-1:0] tick_t;

	// Indexes the eight data bits of a frame
	typedef logic [2:0] bit_idx_t;

	localparam tick_t TICK_LAST = tick_t'(CLKS_PER_BIT - 1);
	localparam tick_t TICK_HALF = tick_t'(CLKS_PER_BIT / 2 - 1);

	// I/O address map
	localparam io_adr_t ADR_UART_CTRL = 5'd0;
	localparam io_adr_t ADR_UART_RX = 5'd1;
	localparam io_adr_t ADR_UART_TX = 5'd2;
	localparam io_adr_t ADR_CYCLE_CNT = 5'd4;
	localparam io_adr_t ADR_INSTR_CNT = 5'd5;
	localparam io_adr_t ADR_CNT_CLEAR = 5'd6;

	// Member order puts rx_valid at bit 1 and tx_ready at bit 0 of the status word
	typedef struct packed {
		logic rx_valid;
		logic tx_ready;
	} uart_status_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

`default_nettype wire
